/* list.f */
source/rv_pkg.sv
source/control_unit.sv
source/id_stage.sv
source/ex_stage.sv
source/hazard_unit.sv
source/datapath.sv
source/cpu_top.sv
tests/cpu_tb.sv

/* run.sh */
#!/bin/sh
# build and run the cpu testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps --top-module cpu_tb -f list.f -o cpu_sim
output=$(./obj_dir/cpu_sim)
echo "$output"

if echo "$output" | grep -qx "Test OK"; then
    exit 0
fi
exit 1

/* source/control_unit.sv */
`timescale 1ns/1ps

module control_unit import rv_pkg::*; (
    input  opcode_e    opcode_i,
    input  logic [2:0] funct3_i,
    input  logic       funct7_5_i,
    output ctrl_t      ctrl_o
);

    always_comb begin
        ctrl_o = '0;
        case (opcode_i)
            OPC_OP, OPC_OP_IMM: begin
                ctrl_o.reg_write     = 1'b1;
                ctrl_o.alu_src_b_imm = (opcode_i == OPC_OP_IMM);
                case (funct3_i)
                    3'b000: begin
                        // funct7 bit 5 selects sub only for register ops
                        if (opcode_i == OPC_OP && funct7_5_i) begin
                            ctrl_o.alu_op = ALU_SUB;
                        end else begin
                            ctrl_o.alu_op = ALU_ADD;
                        end
                    end
                    3'b010:  ctrl_o.alu_op = ALU_SLT;
                    3'b100:  ctrl_o.alu_op = ALU_XOR;
                    3'b110:  ctrl_o.alu_op = ALU_OR;
                    3'b111:  ctrl_o.alu_op = ALU_AND;
                    default: ctrl_o = '0;
                endcase
            end
            OPC_LUI: begin
                ctrl_o.alu_op        = ALU_PASS_B;
                ctrl_o.alu_src_b_imm = 1'b1;
                ctrl_o.reg_write     = 1'b1;
            end
            OPC_LOAD: begin
                ctrl_o.alu_src_b_imm = 1'b1;
                ctrl_o.reg_write     = 1'b1;
                ctrl_o.mem_read      = 1'b1;
            end
            OPC_STORE: begin
                ctrl_o.alu_src_b_imm = 1'b1;
                ctrl_o.mem_write     = 1'b1;
            end
            OPC_BRANCH: begin
                case (funct3_i)
                    3'b000:  ctrl_o.branch = BR_BEQ;
                    3'b001:  ctrl_o.branch = BR_BNE;
                    3'b100:  ctrl_o.branch = BR_BLT;
                    default: ctrl_o.branch = BR_NONE;
                endcase
            end
            OPC_JAL: begin
                // link value replaces the alu result in ex
                ctrl_o.alu_src_a_pc  = 1'b1;
                ctrl_o.alu_src_b_imm = 1'b1;
                ctrl_o.branch        = BR_JAL;
                ctrl_o.reg_write     = 1'b1;
            end
            default: ctrl_o = '0;
        endcase
    end

endmodule

/* source/cpu_top.sv */
`timescale 1ns/1ps

module cpu_top import rv_pkg::*; #(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
    input  logic        clk,
    input  logic        rst_n_i,
    input  logic [31:0] instr_i,
    input  logic [31:0] load_data_i,
    output logic [31:0] rom_addr_o,
    output logic [31:0] ram_addr_o,
    output logic        r_en_o,
    output logic        w_en_o,
    output logic [31:0] store_data_o
);

    ctrl_t      ctrl;
    opcode_e    opcode;
    logic [2:0] funct3;
    logic       funct7_5;

    control_unit u_control_unit (
        .opcode_i   (opcode),
        .funct3_i   (funct3),
        .funct7_5_i (funct7_5),
        .ctrl_o     (ctrl)
    );

    datapath #(
        .RESET_PC (RESET_PC)
    ) u_datapath (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .instr_i      (instr_i),
        .load_data_i  (load_data_i),
        .ctrl_i       (ctrl),
        .rom_addr_o   (rom_addr_o),
        .ram_addr_o   (ram_addr_o),
        .r_en_o       (r_en_o),
        .w_en_o       (w_en_o),
        .store_data_o (store_data_o),
        .opcode_o     (opcode),
        .funct3_o     (funct3),
        .funct7_5_o   (funct7_5)
    );

endmodule

/* source/datapath.sv */
`timescale 1ns/1ps

module datapath import rv_pkg::*; #(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
    input  logic        clk,
    input  logic        rst_n_i,
    input  logic [31:0] instr_i,
    input  logic [31:0] load_data_i,
    input  ctrl_t       ctrl_i,
    output logic [31:0] rom_addr_o,
    output logic [31:0] ram_addr_o,
    output logic        r_en_o,
    output logic        w_en_o,
    output logic [31:0] store_data_o,
    output opcode_e     opcode_o,
    output logic [2:0]  funct3_o,
    output logic        funct7_5_o
);

    logic [31:0] pc_q;
    if_id_t      if_id_q;
    id_ex_t      id_ex_q;
    id_ex_t      id_ex_d;
    ex_mem_t     ex_mem_q;
    mem_wb_t     mem_wb_q;

    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic [31:0] imm;
    logic [31:0] ex_result;
    logic [31:0] ex_store_data;
    logic        taken;
    logic [31:0] target;
    logic        stall;
    logic        flush;

    // decode fields
    assign opcode_o   = opcode_e'(if_id_q.instr[6:0]);
    assign funct3_o   = if_id_q.instr[14:12];
    assign funct7_5_o = if_id_q.instr[30];

    assign rom_addr_o = pc_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q <= RESET_PC;
        end else if (flush) begin
            pc_q <= target;
        end else if (!stall) begin
            pc_q <= pc_q + 32'd4;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            if_id_q <= '0;
        end else if (flush) begin
            if_id_q.valid <= 1'b0;
        end else if (!stall) begin
            if_id_q.valid <= 1'b1;
            if_id_q.pc    <= pc_q;
            if_id_q.instr <= instr_i;
        end
    end

    id_stage u_id_stage (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .instr_i    (if_id_q.instr),
        .wb_i       (mem_wb_q),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .imm_o      (imm)
    );

    always_comb begin
        id_ex_d.valid    = if_id_q.valid;
        id_ex_d.pc       = if_id_q.pc;
        id_ex_d.rs1      = if_id_q.instr[19:15];
        id_ex_d.rs2      = if_id_q.instr[24:20];
        id_ex_d.rd       = if_id_q.instr[11:7];
        id_ex_d.rs1_data = rs1_data;
        id_ex_d.rs2_data = rs2_data;
        id_ex_d.imm      = imm;
        id_ex_d.ctrl     = ctrl_i;
    end

    hazard_unit u_hazard_unit (
        .rs1_i         (id_ex_d.rs1),
        .rs2_i         (id_ex_d.rs2),
        .ex_rd_i       (id_ex_q.rd),
        .ex_mem_read_i (id_ex_q.valid && id_ex_q.ctrl.mem_read),
        .taken_i       (taken),
        .stall_o       (stall),
        .flush_o       (flush)
    );

    // bubble on stall or redirect
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            id_ex_q <= '0;
        end else if (flush || stall) begin
            id_ex_q <= '0;
        end else begin
            id_ex_q <= id_ex_d;
        end
    end

    ex_stage u_ex_stage (
        .id_ex_i      (id_ex_q),
        .ex_mem_i     (ex_mem_q),
        .mem_wb_i     (mem_wb_q),
        .result_o     (ex_result),
        .store_data_o (ex_store_data),
        .taken_o      (taken),
        .target_o     (target)
    );

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ex_mem_q <= '0;
        end else begin
            ex_mem_q.valid      <= id_ex_q.valid;
            ex_mem_q.result     <= ex_result;
            ex_mem_q.store_data <= ex_store_data;
            ex_mem_q.rd         <= id_ex_q.rd;
            ex_mem_q.reg_write  <= id_ex_q.ctrl.reg_write;
            ex_mem_q.mem_read   <= id_ex_q.ctrl.mem_read;
            ex_mem_q.mem_write  <= id_ex_q.ctrl.mem_write;
        end
    end

    assign ram_addr_o   = ex_mem_q.result;
    assign store_data_o = ex_mem_q.store_data;
    assign r_en_o       = ex_mem_q.valid && ex_mem_q.mem_read;
    assign w_en_o       = ex_mem_q.valid && ex_mem_q.mem_write;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mem_wb_q <= '0;
        end else begin
            mem_wb_q.valid     <= ex_mem_q.valid;
            mem_wb_q.wb_data   <= ex_mem_q.mem_read ? load_data_i : ex_mem_q.result;
            mem_wb_q.rd        <= ex_mem_q.rd;
            mem_wb_q.reg_write <= ex_mem_q.reg_write;
        end
    end

endmodule

/* source/ex_stage.sv */
`timescale 1ns/1ps

module ex_stage import rv_pkg::*; (
    input  id_ex_t      id_ex_i,
    input  ex_mem_t     ex_mem_i,
    input  mem_wb_t     mem_wb_i,
    output logic [31:0] result_o,
    output logic [31:0] store_data_o,
    output logic        taken_o,
    output logic [31:0] target_o
);

    logic [31:0] fwd_a;
    logic [31:0] fwd_b;
    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [31:0] alu_out;
    logic        cond;

    // newest producer wins
    function automatic logic [31:0] forward(
        input logic [4:0]  rs,
        input logic [31:0] reg_data,
        input ex_mem_t     ex_mem,
        input mem_wb_t     mem_wb
    );
        if (ex_mem.valid && ex_mem.reg_write && ex_mem.rd != 5'd0 && ex_mem.rd == rs) begin
            return ex_mem.result;
        end
        if (mem_wb.valid && mem_wb.reg_write && mem_wb.rd != 5'd0 && mem_wb.rd == rs) begin
            return mem_wb.wb_data;
        end
        return reg_data;
    endfunction

    assign fwd_a = forward(id_ex_i.rs1, id_ex_i.rs1_data, ex_mem_i, mem_wb_i);
    assign fwd_b = forward(id_ex_i.rs2, id_ex_i.rs2_data, ex_mem_i, mem_wb_i);

    assign op_a = id_ex_i.ctrl.alu_src_a_pc  ? id_ex_i.pc  : fwd_a;
    assign op_b = id_ex_i.ctrl.alu_src_b_imm ? id_ex_i.imm : fwd_b;

    always_comb begin
        case (id_ex_i.ctrl.alu_op)
            ALU_ADD:    alu_out = op_a + op_b;
            ALU_SUB:    alu_out = op_a - op_b;
            ALU_AND:    alu_out = op_a & op_b;
            ALU_OR:     alu_out = op_a | op_b;
            ALU_XOR:    alu_out = op_a ^ op_b;
            ALU_SLT:    alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_PASS_B: alu_out = op_b;
            default:    alu_out = '0;
        endcase
    end

    // branch compare always uses register operands
    always_comb begin
        case (id_ex_i.ctrl.branch)
            BR_BEQ:  cond = (fwd_a == fwd_b);
            BR_BNE:  cond = (fwd_a != fwd_b);
            BR_BLT:  cond = ($signed(fwd_a) < $signed(fwd_b));
            BR_JAL:  cond = 1'b1;
            default: cond = 1'b0;
        endcase
    end

    assign taken_o  = id_ex_i.valid && cond;
    assign target_o = id_ex_i.pc + id_ex_i.imm;

    // jal links pc+4
    assign result_o = (id_ex_i.ctrl.branch == BR_JAL) ? id_ex_i.pc + 32'd4 : alu_out;

    assign store_data_o = fwd_b;

endmodule

/* source/hazard_unit.sv */
`timescale 1ns/1ps

module hazard_unit (
    input  logic [4:0] rs1_i,
    input  logic [4:0] rs2_i,
    input  logic [4:0] ex_rd_i,
    input  logic       ex_mem_read_i,
    input  logic       taken_i,
    output logic       stall_o,
    output logic       flush_o
);

    logic load_use;

    // load result not ready until wb, one bubble is enough
    assign load_use = ex_mem_read_i && (ex_rd_i != 5'd0) &&
                      ((ex_rd_i == rs1_i) || (ex_rd_i == rs2_i));

    assign flush_o = taken_i;

    // decode instr is discarded anyway on a redirect
    assign stall_o = load_use && !taken_i;

endmodule

/* source/id_stage.sv */
`timescale 1ns/1ps

module id_stage import rv_pkg::*; (
    input  logic        clk,
    input  logic        rst_n_i,
    input  logic [31:0] instr_i,
    input  mem_wb_t     wb_i,
    output logic [31:0] rs1_data_o,
    output logic [31:0] rs2_data_o,
    output logic [31:0] imm_o
);

    logic [31:0] regs [31:1];
    logic        wb_en;
    opcode_e     opcode;

    assign wb_en  = wb_i.valid && wb_i.reg_write && (wb_i.rd != 5'd0);
    assign opcode = opcode_e'(instr_i[6:0]);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en) begin
            regs[wb_i.rd] <= wb_i.wb_data;
        end
    end

    // x0 reads zero, same-cycle write bypasses the array
    function automatic logic [31:0] read_reg(input logic [4:0] addr);
        if (addr == 5'd0) begin
            return '0;
        end
        if (wb_en && wb_i.rd == addr) begin
            return wb_i.wb_data;
        end
        return regs[addr];
    endfunction

    assign rs1_data_o = read_reg(instr_i[19:15]);
    assign rs2_data_o = read_reg(instr_i[24:20]);

    always_comb begin
        case (opcode)
            OPC_OP_IMM, OPC_LOAD: imm_o = {{20{instr_i[31]}}, instr_i[31:20]};
            OPC_STORE:  imm_o = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
            OPC_BRANCH: imm_o = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                                 instr_i[30:25], instr_i[11:8], 1'b0};
            OPC_LUI:    imm_o = {instr_i[31:12], 12'b0};
            OPC_JAL:    imm_o = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12],
                                 instr_i[20], instr_i[30:21], 1'b0};
            default:    imm_o = '0;
        endcase
    end

endmodule

/* source/rv_pkg.sv */
package rv_pkg;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_AND    = 4'd2,
        ALU_OR     = 4'd3,
        ALU_XOR    = 4'd4,
        ALU_SLT    = 4'd5,
        ALU_PASS_B = 4'd6
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE = 3'd0,
        BR_BEQ  = 3'd1,
        BR_BNE  = 3'd2,
        BR_BLT  = 3'd3,
        BR_JAL  = 3'd4
    } branch_e;

    // all zero is a no-op
    typedef struct packed {
        alu_op_e     alu_op;
        logic        alu_src_a_pc;
        logic        alu_src_b_imm;
        branch_e     branch;
        logic        reg_write;
        logic        mem_read;
        logic        mem_write;
    } ctrl_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] instr;
    } if_id_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [31:0] rs1_data;
        logic [31:0] rs2_data;
        logic [31:0] imm;
        ctrl_t       ctrl;
    } id_ex_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] result;
        logic [31:0] store_data;
        logic [4:0]  rd;
        logic        reg_write;
        logic        mem_read;
        logic        mem_write;
    } ex_mem_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] wb_data;
        logic [4:0]  rd;
        logic        reg_write;
    } mem_wb_t;

endpackage

/* tests/cpu_tb.sv */
`timescale 1ns/1ps

module cpu_tb;

    localparam logic [31:0] RESET_PC   = 32'h0000_0000;
    localparam logic [31:0] NOP        = 32'h0000_0013;
    localparam logic [31:0] SENTINEL   = 32'h0000_00FC;
    localparam int          STIM_WORDS = 64;

    logic        clk;
    logic        rst_n;
    logic [31:0] instr;
    logic [31:0] load_data;
    logic [31:0] rom_addr;
    logic [31:0] ram_addr;
    logic        r_en;
    logic        w_en;
    logic [31:0] store_data;

    logic [31:0] stim [0:STIM_WORDS-1];
    logic [31:0] rom [0:63];
    logic [31:0] ram [0:63];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    logic [31:0] prog_len;
    int          store_idx = 0;
    int          check_errors = 0;
    int          setup_errors;
    bit          stim_loaded = 1'b0;
    bit          sentinel_seen = 1'b0;

    cpu_top #(
        .RESET_PC (RESET_PC)
    ) dut (
        .clk          (clk),
        .rst_n_i      (rst_n),
        .instr_i      (instr),
        .load_data_i  (load_data),
        .rom_addr_o   (rom_addr),
        .ram_addr_o   (ram_addr),
        .r_en_o       (r_en),
        .w_en_o       (w_en),
        .store_data_o (store_data)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // instruction rom returns nop past the end of the program
    always_comb begin
        if (rom_addr < (prog_len << 2)) begin
            instr = rom[rom_addr[7:2]];
        end else begin
            instr = NOP;
        end
    end

    // read data only while the read enable is high
    assign load_data = (r_en && ram_addr < 32'h100) ? ram[ram_addr[7:2]] : 32'h0;

    // random fill while in reset, so only stored words are known
    always @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 64; i++) begin
                ram[i] <= $urandom;
            end
        end else if (w_en && ram_addr < 32'h100) begin
            ram[ram_addr[7:2]] <= store_data;
        end
    end

    always @(negedge clk) begin
        if (!rst_n) begin
            assert (rom_addr == RESET_PC) else begin
                check_errors++;
                $display("mismatch rom_addr_o: expected %h, got %h", RESET_PC, rom_addr);
            end
            assert (!r_en) else begin
                check_errors++;
                $display("mismatch r_en_o: expected %h, got %h", 1'b0, r_en);
            end
            assert (!w_en) else begin
                check_errors++;
                $display("mismatch w_en_o: expected %h, got %h", 1'b0, w_en);
            end
        end else begin
            if (store_idx == 0) begin
                assert (!r_en) else begin
                    check_errors++;
                    $display("mismatch r_en_o: expected %h, got %h", 1'b0, r_en);
                end
            end
            if (w_en) begin
                assert (store_idx < exp_addr.size()) else begin
                    check_errors++;
                    $display("store to %h came after the expected list ran out", ram_addr);
                end
                if (store_idx < exp_addr.size()) begin
                    assert (ram_addr == exp_addr[store_idx]) else begin
                        check_errors++;
                        $display("mismatch ram_addr_o: expected %h, got %h",
                                 exp_addr[store_idx], ram_addr);
                    end
                    assert (store_data == exp_data[store_idx]) else begin
                        check_errors++;
                        $display("mismatch store_data_o: expected %h, got %h",
                                 exp_data[store_idx], store_data);
                    end
                    store_idx++;
                end
                if (ram_addr == SENTINEL) begin
                    sentinel_seen = 1'b1;
                end
            end
        end
    end

    // word 0 is the length, then the program, then address/data pairs
    task automatic load_program();
        int idx;
        prog_len = stim[0];
        for (int i = 0; i < 64; i++) begin
            rom[i] = (i < int'(prog_len)) ? stim[i + 1] : NOP;
        end
        idx = int'(prog_len) + 1;
        while (idx + 1 < STIM_WORDS) begin
            exp_addr.push_back(stim[idx]);
            exp_data.push_back(stim[idx + 1]);
            if (stim[idx] == SENTINEL) begin
                break;
            end
            idx += 2;
        end
    endtask

    task automatic finish_run(input bit timed_out);
        $display("errors: %0d check, %0d setup, %0d timeout", check_errors, setup_errors,
                 timed_out);
        if (check_errors == 0 && setup_errors == 0 && !timed_out) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    endtask

    initial begin
        rst_n = 1'b0;
        setup_errors = 0;
        void'($urandom(94));
        for (int i = 0; i < STIM_WORDS; i++) begin
            stim[i] = '0;
        end
        $readmemh("tests/program_stimulus.mem", stim);
        load_program();
        stim_loaded = 1'b1;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        assert (rom_addr == RESET_PC) else begin
            setup_errors++;
            $display("mismatch rom_addr_o: expected %h, got %h", RESET_PC, rom_addr);
        end
        wait (sentinel_seen);
        // a few more cycles to catch stray stores
        repeat (4) @(posedge clk);
        assert (store_idx == exp_addr.size()) else begin
            setup_errors++;
            $display("only %0d of %0d expected stores were seen", store_idx, exp_addr.size());
        end
        finish_run(1'b0);
    end

    initial begin
        int limit;
        wait (stim_loaded);
        limit = int'(prog_len) * 4 + 50;
        repeat (limit) @(posedge clk);
        $display("run timed out, sentinel store not seen within %0d clock cycles", limit);
        finish_run(1'b1);
    end

endmodule

/* tests/program_stimulus.mem */
// word 0: program length in words, then the program words (four per line)
// then expected stores as address data pairs, ending with the sentinel at 0xfc
00000020
00500093 FFD00113 002081B3 40118233  // 0x00 addi, addi, add, sub
00302023 00402223 123452B7 0012C333  // 0x10 sw, sw, lui, xor
002363B3 0062F433 001124B3 00602423  // 0x20 or, and, slt, sw
00702623 00802823 00902A23 00002503  // 0x30 sw, sw, sw, lw
001505B3 00B02C23 00318463 0E102823  // 0x40 add after load, sw, beq taken, poison
00319463 00102E23 00114463 0E102823  // 0x50 bne not taken, sw, blt taken, poison
0020C463 00208463 00209463 0E102823  // 0x60 blt not taken, beq not taken, bne taken, poison
0080066F 0E102823 02C02023 0E102E23  // 0x70 jal, poison, sw link, sentinel
00000000 00000002
00000004 FFFFFFFD
00000008 12345005
0000000C FFFFFFFD
00000010 12345000
00000014 00000001
00000018 00000007
0000001C 00000005
00000020 00000074
000000FC 00000005
